// ==== bench/muldiv_model.svh ====
//----------------------------------------------------------
// reference model: expected muldiv response for a request
//----------------------------------------------------------
`ifndef MULDIV_MODEL_SVH
`define MULDIV_MODEL_SVH

// divide packs {remainder, quotient}, multiply the full product
function automatic muldiv_pkg::muldiv_resp_t muldiv_model(input muldiv_pkg::muldiv_req_t r);
  muldiv_pkg::muldiv_resp_t rsp;
  longint                   sa;
  longint                   sb;
  longint                   q;
  longint                   rm;
  logic [31:0]              uq;
  logic [31:0]              ur;

  // 64-bit signed views, so min / -1 cannot overflow
  sa = longint'($signed(r.a));
  sb = longint'($signed(r.b));
  rsp.tag = r.tag;
  case (r.fn)
    muldiv_pkg::fn_mul: begin
      rsp.result = sa * sb;
    end
    muldiv_pkg::fn_div: begin
      if (r.b == 32'h0) begin
        // all-ones quotient, dividend comes back as remainder
        rsp.result = {r.a, 32'hffff_ffff};
      end else if (r.a == 32'h8000_0000 && r.b == 32'hffff_ffff) begin
        // overflow case keeps the dividend, no remainder
        rsp.result = {32'h0, r.a};
      end else begin
        // truncating divide, remainder carries the dividend's sign
        q  = sa / sb;
        rm = sa % sb;
        rsp.result = {rm[31:0], q[31:0]};
      end
    end
    muldiv_pkg::fn_divu: begin
      if (r.b == 32'h0) begin
        rsp.result = {r.a, 32'hffff_ffff};
      end else begin
        uq = r.a / r.b;
        ur = r.a % r.b;
        rsp.result = {ur, uq};
      end
    end
    default: rsp.result = '0;
  endcase
  return rsp;
endfunction

`endif

// ==== bench/muldiv_tb.sv ====
//----------------------------------------------------------
// testbench for the muldiv unit with credit-aware stimulus,
// response checks against the reference model and stalls
//----------------------------------------------------------
`timescale 1ns/1ns
`include "muldiv_defines.svh"

module muldiv_tb;

  import muldiv_pkg::*;

  `include "muldiv_model.svh"

  // 20 div + 20 divu + 20 mul + 8 corner + 7 held + 12 burst
  localparam int num_reqs    = 87;
  localparam int cycle_limit = num_reqs * 40 * 2 + 500;

  logic         clk;
  logic         reset;
  logic         req_valid;
  muldiv_req_t  req;
  logic         req_credit;
  logic         resp_valid;
  muldiv_resp_t resp;
  logic         resp_credit;

  // expected responses in request order
  muldiv_resp_t exp_q[$];

  int sent_count       = 0;
  int credit_pulses    = 0;
  int resp_count       = 0;
  int credits_returned = 0;
  int hold_pulses      = 0;
  int cycle_count      = 0;
  int error_count      = 0;
  logic hold_credits   = 1'b0;

  muldiv_unit u_muldiv_unit (
    .clk         (clk),
    .reset       (reset),
    .req_valid   (req_valid),
    .req         (req),
    .req_credit  (req_credit),
    .resp_valid  (resp_valid),
    .resp        (resp),
    .resp_credit (resp_credit)
  );

  //----------------------------------------------------------
  // clock, failure reporting, compare
  //----------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      error_count++;
      stop_with_failure($sformatf("ERR %s got %h expected %h", name, got, exp));
    end
  endtask

  // every response is matched against the oldest expected one
  always @(posedge clk) begin : compare_resp
    muldiv_resp_t exp_rsp;
    if (!reset && resp_valid) begin
      if (exp_q.size() == 0) begin
        stop_with_failure("a response arrived with no request outstanding");
      end else begin
        exp_rsp = exp_q.pop_front();
        check_value("resp.tag", 64'(resp.tag), 64'(exp_rsp.tag));
        check_value("resp.result", resp.result, exp_rsp.result);
        resp_count <= resp_count + 1;
      end
    end
  end

  // count req_credit pulses and the responses seen while credits are withheld
  always @(posedge clk) begin
    if (!reset && req_credit) begin
      credit_pulses <= credit_pulses + 1;
    end
    if (!reset && resp_valid && hold_credits) begin
      if (hold_pulses >= `MULDIV_RESP_CREDITS) begin
        stop_with_failure("more responses than response credits while credits were held");
      end else begin
        hold_pulses <= hold_pulses + 1;
      end
    end
  end

  // nothing may come out of the unit before the first request
  always @(posedge clk) begin
    if (!reset && sent_count == 0) begin
      if (resp_valid) begin
        stop_with_failure("resp_valid pulsed before any request was sent");
      end
      if (req_credit) begin
        stop_with_failure("req_credit pulsed before any request was sent");
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      stop_with_failure("timeout: the unit stopped answering requests");
    end
  end

  //----------------------------------------------------------
  // consumer side
  //----------------------------------------------------------

  // one credit back per received response after a random gap
  initial begin : return_credits
    int gap;
    resp_credit = 1'b0;
    forever begin
      @(posedge clk);
      if (!reset && !hold_credits && credits_returned < resp_count) begin
        gap = $urandom_range(0, 5);
        repeat (gap) @(posedge clk);
        resp_credit <= 1'b1;
        @(posedge clk);
        resp_credit <= 1'b0;
        credits_returned++;
      end
    end
  end

  //----------------------------------------------------------
  // sender side
  //----------------------------------------------------------

  // mixed signs and magnitudes
  function automatic logic [31:0] random_operand();
    logic [31:0] v;
    v = $urandom;
    if ($urandom_range(0, 1) == 1) begin
      v = v >> $urandom_range(0, 30);
    end
    if ($urandom_range(0, 1) == 1) begin
      v = -v;
    end
    return v;
  endfunction

  // waits at an edge for a free credit, then drives one request
  task automatic send_req(input muldiv_fn_e fn, input logic [31:0] a, input logic [31:0] b);
    muldiv_req_t r;
    @(posedge clk);
    while (`MULDIV_REQ_CREDITS - sent_count + credit_pulses <= 0) begin
      req_valid <= 1'b0;
      @(posedge clk);
    end
    r.fn  = fn;
    r.a   = a;
    r.b   = b;
    r.tag = sent_count[3:0];
    req_valid <= 1'b1;
    req       <= r;
    exp_q.push_back(muldiv_model(r));
    sent_count++;
  endtask

  task automatic end_burst();
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  // wait until every response is in and every response credit is back
  task automatic wait_drain();
    wait (resp_count == sent_count && credits_returned == resp_count);
    @(posedge clk);
  endtask

  initial begin : stimulus
    void'($urandom(22));
    reset     = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    // quiet stretch after reset
    repeat (20) @(posedge clk);

    // random division with both opcodes
    for (int i = 0; i < 20; i++) begin
      send_req(fn_div, random_operand(), random_operand());
    end
    for (int i = 0; i < 20; i++) begin
      send_req(fn_divu, random_operand(), random_operand());
    end
    end_burst();
    wait_drain();

    // random signed multiply
    for (int i = 0; i < 20; i++) begin
      send_req(fn_mul, random_operand(), random_operand());
    end
    end_burst();
    wait_drain();

    // corner divisions
    send_req(fn_div, 32'd123, 32'd0);
    send_req(fn_div, -32'sd7, 32'd0);
    send_req(fn_divu, 32'hdead_beef, 32'd0);
    send_req(fn_div, 32'h8000_0000, 32'hffff_ffff);
    send_req(fn_div, 32'd5, 32'd9);
    send_req(fn_div, -32'sd5, 32'd9);
    send_req(fn_divu, 32'd3, 32'hffff_ffff);
    send_req(fn_div, 32'd7, -32'sd2);
    end_burst();
    wait_drain();

    // response credits withheld while the queue fills behind the stall
    hold_credits <= 1'b1;
    for (int i = 0; i < 7; i++) begin
      send_req(muldiv_fn_e'($urandom_range(0, 2)), random_operand(), random_operand());
    end
    end_burst();
    repeat (300) @(posedge clk);
    hold_credits <= 1'b0;
    wait_drain();

    // back to back until the request credits run out
    for (int i = 0; i < 12; i++) begin
      send_req(muldiv_fn_e'($urandom_range(0, 2)), random_operand(), random_operand());
    end
    end_burst();
    wait_drain();

    check_value("req_credit pulses", 64'(credit_pulses), 64'(sent_count));
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== common/muldiv_defines.svh ====
//----------------------------------------------------------
// muldiv sizing macros: word width and the credit counts
// on the request and response sides
//----------------------------------------------------------
`ifndef MULDIV_DEFINES_SVH
`define MULDIV_DEFINES_SVH

// operand width
`define MULDIV_XLEN 32

// request queue depth, equal to the sender's starting credits
`define MULDIV_REQ_CREDITS 4

// response credits held by the unit after reset
`define MULDIV_RESP_CREDITS 2

`endif

// ==== common/muldiv_pkg.sv ====
//----------------------------------------------------------
// muldiv types: opcodes, control states, request and
// response structs
//----------------------------------------------------------
`include "muldiv_defines.svh"

package muldiv_pkg;

  //----------------------------------------------------------
  // opcodes
  //----------------------------------------------------------

  // only the signed multiply is supported
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } muldiv_fn_e;

  //----------------------------------------------------------
  // control states
  //----------------------------------------------------------

  typedef enum logic [1:0] {
    idle = 2'd0,
    load = 2'd1,
    calc = 2'd2,
    done = 2'd3
  } muldiv_state_e;

  //----------------------------------------------------------
  // messages
  //----------------------------------------------------------

  // request, 70 bits
  typedef struct packed {
    muldiv_fn_e              fn;
    logic [`MULDIV_XLEN-1:0] a;
    logic [`MULDIV_XLEN-1:0] b;
    logic [3:0]              tag;
  } muldiv_req_t;

  // response, 68 bits
  // divide puts the remainder on top and the quotient below
  typedef struct packed {
    logic [2*`MULDIV_XLEN-1:0] result;
    logic [3:0]                tag;
  } muldiv_resp_t;

endpackage

// ==== logic/req_queue.sv ====
//----------------------------------------------------------
// request FIFO sized to the sender's credits, one credit
// pulse back per popped entry
//----------------------------------------------------------
`timescale 1ns/1ns
`include "muldiv_defines.svh"

module req_queue (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    push,
  input  muldiv_pkg::muldiv_req_t push_data,
  input  logic                    pop,
  output muldiv_pkg::muldiv_req_t head,
  output logic                    empty,
  output logic                    credit
);

  import muldiv_pkg::*;

  localparam int depth = `MULDIV_REQ_CREDITS;
  localparam int ptr_w = $clog2(depth);

  muldiv_req_t      mem [depth];
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w-1:0] wr_ptr;
  // one extra bit to tell full from empty
  logic [ptr_w:0]   count;
  logic             full;

  assign empty = (count == '0);
  assign full  = (count == (ptr_w + 1)'(depth));
  assign head  = mem[rd_ptr];

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // freed slot goes back to the sender
      credit <= pop;
    end
  end

  // sender pushing without a credit lands here
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    push |-> !full)
    else $error("request pushed into a full queue");

endmodule

// ==== muldiv/div_dpath.sv ====
//----------------------------------------------------------
// restoring shift-subtract divider, 32 steps, with sign
// unpacking and quotient/remainder sign fixup
//----------------------------------------------------------
`timescale 1ns/1ns
`include "muldiv_defines.svh"

module div_dpath (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      load,
  input  logic                      step,
  input  logic                      is_signed,
  input  logic [`MULDIV_XLEN-1:0]   op_a,
  input  logic [`MULDIV_XLEN-1:0]   op_b,
  output logic [2*`MULDIV_XLEN-1:0] result
);

  localparam int xlen = `MULDIV_XLEN;

  // remainder in the upper 33 bits, quotient shifts in below
  logic [2*xlen:0] rq;
  logic [xlen-1:0] divisor;
  logic [xlen-1:0] dividend;
  logic            quo_neg;
  logic            rem_neg;
  logic            div_zero;

  logic            a_neg;
  logic            b_neg;
  logic [xlen-1:0] mag_a;
  logic [xlen-1:0] mag_b;
  logic [2*xlen:0] shifted;
  logic [xlen+1:0] diff;
  logic [xlen-1:0] quot;
  logic [xlen-1:0] rem;
  logic [xlen-1:0] quot_fix;
  logic [xlen-1:0] rem_fix;

  //----------------------------------------------------------
  // operand unpacking
  //----------------------------------------------------------

  assign a_neg = is_signed & op_a[xlen-1];
  assign b_neg = is_signed & op_b[xlen-1];
  // most negative value maps onto 2^31, which is still correct unsigned
  assign mag_a = a_neg ? (~op_a + 1'b1) : op_a;
  assign mag_b = b_neg ? (~op_b + 1'b1) : op_b;

  // sign flags
  always_ff @(posedge clk) begin
    if (reset) begin
      quo_neg  <= 1'b0;
      rem_neg  <= 1'b0;
      div_zero <= 1'b0;
    end else if (load) begin
      quo_neg  <= a_neg ^ b_neg;
      // remainder follows the dividend
      rem_neg  <= a_neg;
      div_zero <= (op_b == '0);
    end
  end

  //----------------------------------------------------------
  // iteration
  //----------------------------------------------------------

  assign shifted = rq << 1;
  // one spare bit so the borrow shows up in the top bit
  assign diff    = {1'b0, shifted[2*xlen:xlen]} - {2'b0, divisor};

  always_ff @(posedge clk) begin
    if (load) begin
      rq       <= {{(xlen + 1){1'b0}}, mag_a};
      divisor  <= mag_b;
      dividend <= op_a;
    end else if (step) begin
      if (!diff[xlen+1]) begin
        // subtraction fits, keep it and shift in a one
        rq <= {diff[xlen:0], shifted[xlen-1:1], 1'b1};
      end else begin
        // restore, the shift already put a zero in the quotient
        rq <= shifted;
      end
    end
  end

  //----------------------------------------------------------
  // result fixup
  //----------------------------------------------------------

  assign quot     = rq[xlen-1:0];
  assign rem      = rq[2*xlen-1:xlen];
  assign quot_fix = quo_neg ? (~quot + 1'b1) : quot;
  assign rem_fix  = rem_neg ? (~rem + 1'b1) : rem;

  // divide by zero: all-ones quotient, dividend back as remainder
  assign result = div_zero ? {dividend, {xlen{1'b1}}} : {rem_fix, quot_fix};

endmodule

// ==== muldiv/mul_dpath.sv ====
//----------------------------------------------------------
// shift-add multiplier over operand magnitudes, 32 steps,
// full 64-bit product with sign fixup
//----------------------------------------------------------
`timescale 1ns/1ns
`include "muldiv_defines.svh"

module mul_dpath (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      load,
  input  logic                      step,
  input  logic                      is_signed,
  input  logic [`MULDIV_XLEN-1:0]   op_a,
  input  logic [`MULDIV_XLEN-1:0]   op_b,
  output logic [2*`MULDIV_XLEN-1:0] result
);

  localparam int xlen = `MULDIV_XLEN;

  logic [2*xlen-1:0] mcand;
  logic [xlen-1:0]   mplier;
  logic [2*xlen-1:0] acc;
  logic              neg;

  logic              a_neg;
  logic              b_neg;
  logic [xlen-1:0]   mag_a;
  logic [xlen-1:0]   mag_b;

  // magnitudes
  assign a_neg = is_signed & op_a[xlen-1];
  assign b_neg = is_signed & op_b[xlen-1];
  assign mag_a = a_neg ? (~op_a + 1'b1) : op_a;
  assign mag_b = b_neg ? (~op_b + 1'b1) : op_b;

  //----------------------------------------------------------
  // accumulate
  //----------------------------------------------------------

  // accumulator and sign restart on every load
  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
      neg <= 1'b0;
    end else if (load) begin
      acc <= '0;
      neg <= a_neg ^ b_neg;
    end else if (step && mplier[0]) begin
      acc <= acc + mcand;
    end
  end

  // multiplicand walks left, multiplier bits drain out the bottom
  always_ff @(posedge clk) begin
    if (load) begin
      mcand  <= {{xlen{1'b0}}, mag_a};
      mplier <= mag_b;
    end else if (step) begin
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // product sign
  assign result = neg ? (~acc + 1'b1) : acc;

endmodule

// ==== muldiv/muldiv_ctrl.sv ====
//----------------------------------------------------------
// muldiv control FSM over the queue head, with iteration
// count, response credits and result select
//----------------------------------------------------------
`timescale 1ns/1ns
`include "muldiv_defines.svh"

module muldiv_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  input  muldiv_pkg::muldiv_req_t   head,
  input  logic                      empty,
  output logic                      pop,
  output logic                      load,
  output logic                      step,
  output logic                      is_signed,
  output logic [`MULDIV_XLEN-1:0]   op_a,
  output logic [`MULDIV_XLEN-1:0]   op_b,
  input  logic [2*`MULDIV_XLEN-1:0] div_result,
  input  logic [2*`MULDIV_XLEN-1:0] mul_result,
  input  logic                      resp_credit,
  output logic                      resp_valid,
  output muldiv_pkg::muldiv_resp_t  resp
);

  import muldiv_pkg::*;

  localparam int credits = `MULDIV_RESP_CREDITS;
  localparam int cred_w  = $clog2(credits + 1);

  muldiv_state_e     state;
  muldiv_state_e     state_next;
  logic [4:0]        iter;
  logic [cred_w-1:0] resp_credits;
  logic              has_credit;

  // opcode and tag of the operation in flight
  muldiv_fn_e        fn_q;
  logic [3:0]        tag_q;

  assign has_credit = (resp_credits != '0);

  //----------------------------------------------------------
  // next state and strobes
  //----------------------------------------------------------

  // muldiv_pkg::load names the state and plain load the strobe port
  always_comb begin
    state_next = state;
    pop        = 1'b0;
    load       = 1'b0;
    step       = 1'b0;
    resp_valid = 1'b0;
    case (state)
      idle: begin
        if (!empty) begin
          pop        = 1'b1;
          state_next = muldiv_pkg::load;
        end
      end
      muldiv_pkg::load: begin
        load       = 1'b1;
        state_next = calc;
      end
      calc: begin
        step = 1'b1;
        // last of the 32 iterations
        if (iter == 5'd31) begin
          state_next = done;
        end
      end
      done: begin
        // hold the result until the consumer has room
        if (has_credit) begin
          resp_valid = 1'b1;
          state_next = idle;
        end
      end
      default: state_next = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      iter  <= '0;
    end else begin
      state <= state_next;
      if (load) begin
        iter <= '0;
      end else if (step) begin
        iter <= iter + 5'd1;
      end
    end
  end

  // operands and op info are captured while the entry leaves the queue
  always_ff @(posedge clk) begin
    if (pop) begin
      fn_q  <= head.fn;
      tag_q <= head.tag;
      op_a  <= head.a;
      op_b  <= head.b;
    end
  end

  //----------------------------------------------------------
  // response credits
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_credits <= cred_w'(credits);
    end else begin
      case ({resp_credit, resp_valid})
        2'b10:   resp_credits <= resp_credits + 1'b1;
        2'b01:   resp_credits <= resp_credits - 1'b1;
        default: resp_credits <= resp_credits;
      endcase
    end
  end

  // divu is the only unsigned op
  assign is_signed = (fn_q != fn_divu);

  always_comb begin
    resp.result = (fn_q == fn_mul) ? mul_result : div_result;
    resp.tag    = tag_q;
  end

  // consumer never hands back more than it was given
  a_credit_max: assert property (@(posedge clk) disable iff (reset)
    resp_credits <= cred_w'(credits))
    else $error("response credit count above its reset value");

endmodule

// ==== muldiv/muldiv_unit.sv ====
//----------------------------------------------------------
// muldiv unit top: credit-guarded request queue, control
// FSM and the iterative divide and multiply datapaths
//----------------------------------------------------------
`timescale 1ns/1ns
`include "muldiv_defines.svh"

module muldiv_unit (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_valid,
  input  muldiv_pkg::muldiv_req_t  req,
  output logic                     req_credit,
  output logic                     resp_valid,
  output muldiv_pkg::muldiv_resp_t resp,
  input  logic                     resp_credit
);

  import muldiv_pkg::*;

  // queue head toward control
  muldiv_req_t head;
  logic        empty;
  logic        pop;

  // control toward datapaths
  logic                      load;
  logic                      step;
  logic                      is_signed;
  logic [`MULDIV_XLEN-1:0]   op_a;
  logic [`MULDIV_XLEN-1:0]   op_b;

  // datapath results
  logic [2*`MULDIV_XLEN-1:0] div_result;
  logic [2*`MULDIV_XLEN-1:0] mul_result;

  req_queue u_queue (
    .clk       (clk),
    .reset     (reset),
    .push      (req_valid),
    .push_data (req),
    .pop       (pop),
    .head      (head),
    .empty     (empty),
    .credit    (req_credit)
  );

  muldiv_ctrl u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .head        (head),
    .empty       (empty),
    .pop         (pop),
    .load        (load),
    .step        (step),
    .is_signed   (is_signed),
    .op_a        (op_a),
    .op_b        (op_b),
    .div_result  (div_result),
    .mul_result  (mul_result),
    .resp_credit (resp_credit),
    .resp_valid  (resp_valid),
    .resp        (resp)
  );

  div_dpath u_div (
    .clk       (clk),
    .reset     (reset),
    .load      (load),
    .step      (step),
    .is_signed (is_signed),
    .op_a      (op_a),
    .op_b      (op_b),
    .result    (div_result)
  );

  mul_dpath u_mul (
    .clk       (clk),
    .reset     (reset),
    .load      (load),
    .step      (step),
    .is_signed (is_signed),
    .op_a      (op_a),
    .op_b      (op_b),
    .result    (mul_result)
  );

endmodule

// ==== muldiv_unit.f ====
+incdir+common
+incdir+bench
common/muldiv_pkg.sv
logic/req_queue.sv
muldiv/div_dpath.sv
muldiv/mul_dpath.sv
muldiv/muldiv_ctrl.sv
muldiv/muldiv_unit.sv
bench/muldiv_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile muldiv_tb with Verilator, run it and judge the log
set -u

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f muldiv_unit.f --top-module muldiv_tb \
  --Mdir "$obj_dir" -o muldiv_sim
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

"./$obj_dir/muldiv_sim" > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "Simulation failed" "$log"; then
  echo "run reported a failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulator exited with status $run_status"
  exit 1
fi

echo "run finished clean"
exit 0
